// ==== include/vid_params.svh ====
// Video core parameters
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// Pixel/line counters and every timing field
`define VID_CTR_W 11

// Line buffer address, top bit picks the buffer
`define VID_LB_AW 9

// DMA and line-buffer word
`define VID_WORD_W 32

// Palette entry, 4 bits each of R, G, B
`define VID_COL_W 12
`define VID_PAL_N 16

// Output channel
`define VID_OUT_W 8

// Stage 0 to output port latency
`define VID_PIPE 4

`endif

// ==== src/vid_pkg.sv ====
// Video core shared types
`include "vid_params.svh"

package vid_pkg;

   // One line-buffer word seen at each pixel depth
   // Pixel 0 always sits in the least significant bits
   typedef union packed {
      logic [`VID_WORD_W-1:0]          pix1;   // 32 pixels at 1 bpp
      logic [`VID_WORD_W/2-1:0][1:0]   pix2;   // 16 pixels at 2 bpp
      logic [`VID_WORD_W/4-1:0][3:0]   pix4;   // 8 pixels at 4 bpp
   } lb_word_u;

endpackage

// ==== src/frame_resync.sv ====
// Frame resync handshake
`timescale 1ns/10ps

module frame_resync (
   input  logic pclk,
   input  logic i_rst_n,
   input  logic i_cfg_req,        // Toggles when new timing is stable
   input  logic i_flyback,        // Async, from the external source
   output logic o_cfg_ack,
   output logic o_vid_en,         // Releases the timing generator
   output logic o_flyback_fall
);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_hold = 2'd1;
   localparam logic [1:0] st_wait = 2'd2;

   logic [1:0] req_sync;
   logic [2:0] fb_sync;           // Two sync flops plus last value
   logic [1:0] state;
   logic [1:0] hold_cnt;
   logic       req_pending;

   ////////////////////
   // Synchronisers

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         req_sync <= '0;
         fb_sync  <= '0;
      end else begin
         req_sync <= {req_sync[0], i_cfg_req};
         fb_sync  <= {fb_sync[1:0], i_flyback};
      end
   end

   assign req_pending    = req_sync[1] != o_cfg_ack;
   assign o_flyback_fall = fb_sync[2] & ~fb_sync[1];   // Flyback just ended

   ////////////////////
   // Resync sequence

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= st_idle;
         hold_cnt  <= '0;
         o_vid_en  <= 1'b0;      // Stays off until the host asks
         o_cfg_ack <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (req_pending) begin
                  state    <= st_hold;
                  hold_cnt <= 2'd3;
                  o_vid_en <= 1'b0;   // Generator reloads its marks
               end
            end
            st_hold: begin
               // Minimum off time, may miss a flyback and wait a frame
               if (hold_cnt != 2'd0)
                  hold_cnt <= hold_cnt - 2'd1;
               else
                  state <= st_wait;
            end
            st_wait: begin
               if (o_flyback_fall) begin
                  state     <= st_idle;
                  o_vid_en  <= 1'b1;
                  o_cfg_ack <= ~o_cfg_ack;   // Tell host we're locked
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Ack only ever moves together with the generator restart
   ack_with_start: assert property (@(posedge pclk) disable iff (!i_rst_n)
      $changed(o_cfg_ack) |-> $rose(o_vid_en));

endmodule

// ==== src/timing_gen.sv ====
// Programmable video timing generator
`timescale 1ns/10ps
`include "vid_params.svh"

module timing_gen (
   input  logic                 pclk,
   input  logic                 i_rst_n,
   input  logic                 i_vid_en,
   input  logic [`VID_CTR_W-1:0] i_h_res,
   input  logic [`VID_CTR_W-1:0] i_h_fp,
   input  logic [`VID_CTR_W-1:0] i_h_sync,
   input  logic [`VID_CTR_W-1:0] i_h_bp,
   input  logic [`VID_CTR_W-1:0] i_v_res,
   input  logic [`VID_CTR_W-1:0] i_v_fp,
   input  logic [`VID_CTR_W-1:0] i_v_sync,
   input  logic [`VID_CTR_W-1:0] i_v_bp,
   input  logic [1:0]            i_bpp,
   output logic                  o_hsync,
   output logic                  o_vsync,
   output logic                  o_de,
   output logic [`VID_CTR_W-1:0] o_dispx,    // Active pixel from 0
   output logic [`VID_CTR_W-1:0] o_dispy,    // Active line from 0
   output logic [1:0]            o_bpp
);

   localparam logic [`VID_CTR_W-1:0] ctr_one = 1;

   logic [`VID_CTR_W-1:0] h_sync_off;
   logic [`VID_CTR_W-1:0] h_disp_start;
   logic [`VID_CTR_W-1:0] h_disp_end;
   logic [`VID_CTR_W-1:0] h_total;
   logic [`VID_CTR_W-1:0] v_sync_off;
   logic [`VID_CTR_W-1:0] v_disp_start;
   logic [`VID_CTR_W-1:0] v_disp_end;
   logic [`VID_CTR_W-1:0] v_total;
   logic [`VID_CTR_W-1:0] px;
   logic [`VID_CTR_W-1:0] py;
   logic                  v_on;   // Inside the displayed lines
   logic                  ran;    // Has been started at least once

   ////////////////////
   // Config capture

   // Sync sits at coordinate 0, marks are last cycle of each region
   always_ff @(posedge pclk) begin
      if (!i_vid_en) begin
         h_sync_off   <= i_h_sync - ctr_one;
         h_disp_start <= i_h_sync + i_h_bp - ctr_one;
         h_disp_end   <= i_h_sync + i_h_bp + i_h_res - ctr_one;
         h_total      <= i_h_sync + i_h_bp + i_h_res + i_h_fp - ctr_one;
         v_sync_off   <= i_v_sync - ctr_one;
         v_disp_start <= i_v_sync + i_v_bp - ctr_one;
         v_disp_end   <= i_v_sync + i_v_bp + i_v_res - ctr_one;
         v_total      <= i_v_sync + i_v_bp + i_v_res + i_v_fp - ctr_one;
         o_bpp        <= i_bpp;
      end
   end

   ////////////////////
   // Counters and syncs

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         px      <= '0;
         py      <= '0;
         o_hsync <= 1'b0;
         o_vsync <= 1'b0;
         o_de    <= 1'b0;
         v_on    <= 1'b0;
         ran     <= 1'b0;
         o_dispx <= '0;
         o_dispy <= '0;
      end else if (!i_vid_en) begin
         px      <= '0;
         py      <= v_disp_start;     // One line ahead of the display
         o_hsync <= ran;              // Idles low until first start
         o_vsync <= 1'b0;
         o_de    <= 1'b0;
         v_on    <= 1'b0;
         o_dispx <= '0;
         o_dispy <= '0;
      end else begin
         ran     <= 1'b1;
         o_dispx <= o_de ? o_dispx + ctr_one : '0;
         if (px == h_total) begin     // End of line
            px      <= '0;
            o_hsync <= 1'b1;
            o_de    <= 1'b0;
            if (py == v_total) begin
               py      <= '0;
               o_vsync <= 1'b1;
            end else begin
               py <= py + ctr_one;
               if (py == v_sync_off)
                  o_vsync <= 1'b0;
               if (py == v_disp_start) begin
                  v_on <= 1'b1;
               end else if (py == v_disp_end) begin
                  v_on    <= 1'b0;
                  o_dispy <= '0;
               end else if (v_on) begin
                  o_dispy <= o_dispy + ctr_one;
               end
            end
         end else begin
            px <= px + ctr_one;
            if (px == h_sync_off)
               o_hsync <= 1'b0;
            if (px == h_disp_start && v_on)
               o_de <= 1'b1;          // Active from the next pixel
            if (px == h_disp_end)
               o_de <= 1'b0;
         end
      end
   end

   // Active area never overlaps the line sync
   de_outside_hsync: assert property (@(posedge pclk) disable iff (!i_rst_n)
      o_de |-> !o_hsync);

endmodule

// ==== src/line_buffer.sv ====
// Double line buffer
`timescale 1ns/10ps
`include "vid_params.svh"

module line_buffer import vid_pkg::*; (
   input  logic                   pclk,
   input  logic                   i_rst_n,
   input  logic                   i_flyback_fall,
   input  logic                   i_dma_wr,             // One word per strobe
   input  logic [`VID_WORD_W-1:0] i_dma_data,
   input  logic [7:0]             i_words_per_line_m1,
   input  logic [`VID_CTR_W-1:0]  i_dispx,
   input  logic [`VID_CTR_W-1:0]  i_dispy,
   input  logic [1:0]             i_bpp,
   output lb_word_u               o_rdata               // Stage 1
);

   // Even lines in buffer 0, odd lines in buffer 1
   lb_word_u              lb_mem [0:(1 << `VID_LB_AW)-1];
   logic [`VID_LB_AW-1:0] wr_ptr;
   logic [`VID_LB_AW-1:0] rd_idx;

   ////////////////////
   // DMA write side

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
      end else if (i_flyback_fall) begin
         wr_ptr <= '0;                                   // Frame start, buffer 0
      end else if (i_dma_wr) begin
         if (wr_ptr[`VID_LB_AW-2:0] != i_words_per_line_m1)
            wr_ptr <= wr_ptr + 1'b1;
         else
            wr_ptr <= {~wr_ptr[`VID_LB_AW-1], 8'h00};    // Line done, swap
      end
   end

   always_ff @(posedge pclk) begin
      if (i_dma_wr && !i_flyback_fall)
         lb_mem[wr_ptr] <= i_dma_data;
   end

   ////////////////////
   // Scan-out read side

   // Word index scales with pixels per word
   always_comb begin
      case (i_bpp)
         2'd0:    rd_idx = {i_dispy[0], 2'b00, i_dispx[`VID_CTR_W-1:5]};
         2'd1:    rd_idx = {i_dispy[0], 1'b0, i_dispx[`VID_CTR_W-1:4]};
         default: rd_idx = {i_dispy[0], i_dispx[`VID_CTR_W-1:3]};
      endcase
   end

   always_ff @(posedge pclk) begin
      o_rdata <= lb_mem[rd_idx];
   end

   // Host keeps DMA length consistent with the pointer wrap
   dma_in_line: assert property (@(posedge pclk) disable iff (!i_rst_n)
      i_dma_wr && !i_flyback_fall |-> wr_ptr[`VID_LB_AW-2:0] <= i_words_per_line_m1);

endmodule

// ==== src/pixel_path.sv ====
// Pixel lookup and output pipeline
`timescale 1ns/10ps
`include "vid_params.svh"

module pixel_path import vid_pkg::*; (
   input  logic                             pclk,
   input  logic                             i_rst_n,
   input  lb_word_u                         i_rdata,       // Stage 1
   input  logic [`VID_CTR_W-1:0]            i_dispx,       // Stage 0 from here on
   input  logic [`VID_CTR_W-1:0]            i_dispy,
   input  logic [1:0]                       i_bpp,
   input  logic                             i_hsync,
   input  logic                             i_vsync,
   input  logic                             i_de,
   input  logic [`VID_PAL_N*`VID_COL_W-1:0] i_palette,
   input  logic                             i_test_card,
   output logic [`VID_OUT_W-1:0]            o_r,
   output logic [`VID_OUT_W-1:0]            o_g,
   output logic [`VID_OUT_W-1:0]            o_b,
   output logic                             o_hsync,
   output logic                             o_vsync,
   output logic                             o_de,
   output logic                             o_blank
);

   logic [`VID_PIPE-1:0]    hs_d;        // Bit 0 is stage 1
   logic [`VID_PIPE-1:0]    vs_d;
   logic [`VID_PIPE-1:0]    de_d;
   logic                    blank_q;
   logic [`VID_CTR_W-1:0]   dispx_1;
   logic [`VID_CTR_W-1:0]   dispy_1;
   logic [1:0]              bpp_1;
   logic [3:0]              pix_sel;
   logic [3:0]              pix_2;
   logic [`VID_COL_W-1:0]   col_3;
   logic [`VID_CTR_W-1:0]   row_max;     // Latest active row this frame
   logic [`VID_CTR_W-1:0]   last_row;    // Bottom row of the previous frame
   logic                    stripe;
   logic [3*`VID_OUT_W-1:0] tc_2;        // {b, g, r}
   logic [3*`VID_OUT_W-1:0] tc_3;

   // 4 bit channel to 8, top bit fills the low nibble
   function automatic logic [`VID_OUT_W-1:0] expand4(input logic [3:0] nib);
      expand4 = {nib, {4{nib[3]}}};
   endfunction

   ////////////////////
   // Sync delay line

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         hs_d     <= '0;
         vs_d     <= '0;
         de_d     <= '0;
         blank_q  <= 1'b1;
         row_max  <= '0;
         last_row <= '1;                                // No bottom stripe yet
      end else begin
         hs_d    <= {hs_d[`VID_PIPE-2:0], i_hsync};
         vs_d    <= {vs_d[`VID_PIPE-2:0], i_vsync};
         de_d    <= {de_d[`VID_PIPE-2:0], i_de};
         blank_q <= ~de_d[`VID_PIPE-2];                 // Lands with o_de
         if (de_d[0])
            row_max <= dispy_1;
         if (i_vsync && !vs_d[0])
            last_row <= row_max;                        // Learned per frame
      end
   end

   ////////////////////
   // Pixel and colour

   // Pick the pixel through the view matching the depth
   always_comb begin
      case (bpp_1)
         2'd0:    pix_sel = {3'b000, i_rdata.pix1[dispx_1[4:0]]};
         2'd1:    pix_sel = {2'b00, i_rdata.pix2[dispx_1[3:0]]};
         default: pix_sel = i_rdata.pix4[dispx_1[2:0]];
      endcase
   end

   // First/last column and row, stage 0 de low means last pixel
   assign stripe = (dispx_1 == '0) | ~i_de | (dispy_1 == '0) | (dispy_1 == last_row);

   always_ff @(posedge pclk) begin
      dispx_1 <= i_dispx;                               // Stage 1
      dispy_1 <= i_dispy;
      bpp_1   <= i_bpp;
      pix_2   <= pix_sel;                               // Stage 2
      tc_2    <= {dispx_1[8:1] ^ dispy_1[8:1], dispy_1[7:0], dispx_1[7:0]}
                 | {3*`VID_OUT_W{stripe}};
      col_3   <= i_palette[pix_2*`VID_COL_W +: `VID_COL_W];   // Stage 3
      tc_3    <= tc_2;
   end

   ////////////////////
   // Output stage

   always_ff @(posedge pclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_r <= '0;
         o_g <= '0;
         o_b <= '0;
      end else begin
         o_r <= i_test_card ? tc_3[0 +: `VID_OUT_W] : expand4(col_3[3:0]);
         o_g <= i_test_card ? tc_3[`VID_OUT_W +: `VID_OUT_W] : expand4(col_3[7:4]);
         o_b <= i_test_card ? tc_3[2*`VID_OUT_W +: `VID_OUT_W] : expand4(col_3[11:8]);
      end
   end

   assign o_hsync = hs_d[`VID_PIPE-1];
   assign o_vsync = vs_d[`VID_PIPE-1];
   assign o_de    = de_d[`VID_PIPE-1];
   assign o_blank = blank_q;

endmodule

// ==== src/video_timing.sv ====
// Video timing and scan-out top
`timescale 1ns/10ps
`include "vid_params.svh"

module video_timing import vid_pkg::*; (
   input  logic                             pclk,
   input  logic                             i_rst_n,
   input  logic [`VID_CTR_W-1:0]            i_h_res,
   input  logic [`VID_CTR_W-1:0]            i_h_fp,
   input  logic [`VID_CTR_W-1:0]            i_h_sync,
   input  logic [`VID_CTR_W-1:0]            i_h_bp,
   input  logic [`VID_CTR_W-1:0]            i_v_res,
   input  logic [`VID_CTR_W-1:0]            i_v_fp,
   input  logic [`VID_CTR_W-1:0]            i_v_sync,
   input  logic [`VID_CTR_W-1:0]            i_v_bp,
   input  logic [1:0]                       i_bpp,
   input  logic [7:0]                       i_words_per_line_m1,
   input  logic [`VID_PAL_N*`VID_COL_W-1:0] i_palette,
   input  logic                             i_dma_wr,
   input  logic [`VID_WORD_W-1:0]           i_dma_data,
   input  logic                             i_flyback,
   input  logic                             i_cfg_req,
   output logic                             o_cfg_ack,
   input  logic                             i_test_card,
   output logic [`VID_OUT_W-1:0]            o_r,
   output logic [`VID_OUT_W-1:0]            o_g,
   output logic [`VID_OUT_W-1:0]            o_b,
   output logic                             o_hsync,
   output logic                             o_vsync,
   output logic                             o_de,
   output logic                             o_blank
);

   logic                  vid_en;
   logic                  flyback_fall;
   logic                  hsync_0;     // Stage 0 timing
   logic                  vsync_0;
   logic                  de_0;
   logic [`VID_CTR_W-1:0] dispx;
   logic [`VID_CTR_W-1:0] dispy;
   logic [1:0]            bpp;
   lb_word_u              rdata;       // Stage 1 word

   frame_resync resync_i (
      .pclk, .i_rst_n, .i_cfg_req, .i_flyback, .o_cfg_ack,
      .o_vid_en(vid_en), .o_flyback_fall(flyback_fall)
   );

   timing_gen timing_i (
      .pclk, .i_rst_n, .i_vid_en(vid_en),
      .i_h_res, .i_h_fp, .i_h_sync, .i_h_bp,
      .i_v_res, .i_v_fp, .i_v_sync, .i_v_bp, .i_bpp,
      .o_hsync(hsync_0), .o_vsync(vsync_0), .o_de(de_0),
      .o_dispx(dispx), .o_dispy(dispy), .o_bpp(bpp)
   );

   line_buffer lbuf_i (
      .pclk, .i_rst_n, .i_flyback_fall(flyback_fall),
      .i_dma_wr, .i_dma_data, .i_words_per_line_m1,
      .i_dispx(dispx), .i_dispy(dispy), .i_bpp(bpp), .o_rdata(rdata)
   );

   pixel_path pix_i (
      .pclk, .i_rst_n, .i_rdata(rdata),
      .i_dispx(dispx), .i_dispy(dispy), .i_bpp(bpp),
      .i_hsync(hsync_0), .i_vsync(vsync_0), .i_de(de_0),
      .i_palette, .i_test_card,
      .o_r, .o_g, .o_b, .o_hsync, .o_vsync, .o_de, .o_blank
   );

endmodule

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen (
   output logic o_pclk,
   output logic o_rst_n
);

   localparam time half_period = 10ns;   // 20 ns pixel clock
   localparam int  rst_cycles  = 8;

   initial begin
      o_pclk = 1'b0;
      forever #(half_period) o_pclk = ~o_pclk;
   end

   initial begin
      o_rst_n = 1'b1;
      #(1ns);
      o_rst_n = 1'b0;                     // Falling edge starts the async reset
      repeat (rst_cycles) @(posedge o_pclk);
      @(negedge o_pclk);
      o_rst_n = 1'b1;                     // Release away from the active edge
   end

endmodule

// ==== tb/tb_video_timing.sv ====
// Video timing core testbench
`timescale 1ns/10ps
`include "vid_params.svh"

module tb_video_timing;

   localparam int frame_cyc = 48 * 11;
   localparam int n_tests   = 4;
   localparam int limit_ns  = n_tests * 5 * frame_cyc * 20 + 10000;

   logic                             pclk, rst_n;
   logic [`VID_CTR_W-1:0]            h_res, h_fp, h_sync, h_bp;
   logic [`VID_CTR_W-1:0]            v_res, v_fp, v_sync, v_bp;
   logic [1:0]                       bpp;
   logic [7:0]                       wpl_m1;
   logic [`VID_PAL_N*`VID_COL_W-1:0] palette;
   logic                             dma_wr, flyback, cfg_req, cfg_ack, test_card;
   logic [`VID_WORD_W-1:0]           dma_data;
   logic [`VID_OUT_W-1:0]            r, g, b;
   logic                             hsync, vsync, de, blank;

   logic [31:0]           lfsr = 32'h3414_67b4;
   logic [`VID_COL_W-1:0] pal_model [0:`VID_PAL_N-1];
   logic [31:0]           lb_model [0:15];          // Buffer 0 words, then buffer 1
   int   err_timing  = 0;
   int   err_pixel   = 0;
   int   err_hs      = 0;
   int   pix_checked = 0;
   logic started  = 1'b0;
   logic chk_on   = 1'b0;
   logic frame_ok = 1'b0;
   int   chk_mode = 0;                                // 1 test card, 2 bitmap
   int   x = 0, y = 0;
   int   hs_len = 0, hs_per = 0, de_len = 0, de_runs = 0;
   int   vs_len = 0, vs_per = 0;
   logic hs_prev = 0, vs_prev = 0, de_prev = 0;

   tb_clk_gen clk_i (.o_pclk(pclk), .o_rst_n(rst_n));

   video_timing dut_i (
      .pclk, .i_rst_n(rst_n), .i_h_res(h_res), .i_h_fp(h_fp), .i_h_sync(h_sync),
      .i_h_bp(h_bp), .i_v_res(v_res), .i_v_fp(v_fp), .i_v_sync(v_sync), .i_v_bp(v_bp),
      .i_bpp(bpp), .i_words_per_line_m1(wpl_m1), .i_palette(palette),
      .i_dma_wr(dma_wr), .i_dma_data(dma_data), .i_flyback(flyback),
      .i_cfg_req(cfg_req), .o_cfg_ack(cfg_ack), .i_test_card(test_card),
      .o_r(r), .o_g(g), .o_b(b), .o_hsync(hsync), .o_vsync(vsync), .o_de(de),
      .o_blank(blank)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic next_lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], next_lfsr_bit()};
      return v;
   endfunction

   function automatic logic [7:0] widen_nibble(input logic [3:0] n);
      return {n, n[3], n[3], n[3], n[3]};      // Nibble then four copies of its MSB
   endfunction

   ////////////////////
   // Assertions

   blank_tracks_de: assert property (@(posedge pclk) $sampled(blank) == !$sampled(de))
      else begin
         err_timing++;
         $display("ERR o_blank exp %h got %h", !$sampled(de), $sampled(blank));
      end

   idle_before_start: assert property (@(posedge pclk)
      !started |-> (!hsync && !vsync && !de && blank && !cfg_ack))
      else begin
         err_hs++;
         $display("Outputs left their idle values before the first request");
      end

   // Edge counters and the x/y position that follows o_de
   always @(posedge pclk) begin : timing_check
      if (!chk_on)
         frame_ok <= 1'b0;
      else if (vsync && !vs_prev)
         frame_ok <= 1'b1;                                  // Arm on a frame boundary
      if (hsync && !hs_prev) begin
         if (frame_ok) begin
            assert (hs_per == 48) else begin
               err_timing++;
               $display("ERR hsync_period exp %h got %h", 48, hs_per);
            end
         end
         hs_per <= 1;
      end else begin
         hs_per <= hs_per + 1;
      end
      if (!hsync && hs_prev && frame_ok) begin
         assert (hs_len == 4) else begin
            err_timing++;
            $display("ERR hsync_width exp %h got %h", 4, hs_len);
         end
      end
      if (!de && de_prev) begin
         if (frame_ok) begin
            assert (de_len == 32) else begin
               err_timing++;
               $display("ERR de_width exp %h got %h", 32, de_len);
            end
         end
         de_runs <= de_runs + 1;
         y       <= y + 1;
      end
      if (vsync && !vs_prev) begin
         if (frame_ok) begin
            assert (de_runs == 4 && vs_per == frame_cyc) else begin
               err_timing++;
               $display("ERR de_lines exp %h got %h, vsync_period exp %h got %h",
                        4, de_runs, frame_cyc, vs_per);
            end
         end
         de_runs <= 0;
         y       <= 0;
         vs_per  <= 1;
      end else begin
         vs_per <= vs_per + 1;
      end
      if (!vsync && vs_prev && frame_ok) begin
         assert (vs_len == 96) else begin
            err_timing++;
            $display("ERR vsync_width exp %h got %h", 96, vs_len);
         end
      end
      hs_len  <= hsync ? hs_len + 1 : 0;
      de_len  <= de ? de_len + 1 : 0;
      vs_len  <= vsync ? vs_len + 1 : 0;
      x       <= de ? x + 1 : 0;
      hs_prev <= hsync;
      vs_prev <= vsync;
      de_prev <= de;
   end

   // Colour reference for each displayed pixel
   always @(posedge pclk) begin : pixel_check
      logic [23:0] exp_rgb;
      logic [31:0] word;
      logic [3:0]  nib;
      logic [11:0] col;
      int          sh;
      if (frame_ok && de && chk_mode != 0) begin
         if (chk_mode == 1) begin
            if (x == 0 || x == 31 || y == 0 || y == 3)
               exp_rgb = 24'hff_ffff;
            else
               exp_rgb = {8'(x), 8'(y), 8'((x ^ y) >> 1)};
         end else begin
            sh      = 5 - int'(bpp);                         // log2 of pixels per word
            word    = lb_model[(y % 2) * 8 + (x >> sh)];
            nib     = 4'((word >> ((x % (1 << sh)) << bpp)) & ((1 << (1 << bpp)) - 1));
            col     = pal_model[nib];
            exp_rgb = {widen_nibble(col[3:0]), widen_nibble(col[7:4]),
                       widen_nibble(col[11:8])};
         end
         pix_checked++;
         assert ({r, g, b} == exp_rgb) else begin
            err_pixel++;
            $display("ERR rgb exp %h got %h at x %0d y %0d", exp_rgb, {r, g, b}, x, y);
         end
      end
   end

   ////////////////////
   // Stimulus

   task automatic resync(input logic [1:0] new_bpp, input logic tc);
      logic ack_old;
      int   n;
      chk_on    = 1'b0;
      bpp       = new_bpp;
      test_card = tc;
      ack_old   = cfg_ack;
      started   = 1'b1;
      cfg_req   = ~cfg_req;
      for (int i = 0; i < 24; i++) begin
         if (i == 20)
            flyback = 1'b1;
         @(negedge pclk);
         assert (cfg_ack == ack_old) else begin
            err_hs++;
            $display("cfg ack moved before any flyback fall");
         end
      end
      flyback = 1'b0;
      n = 0;
      while (cfg_ack == ack_old && n < 12) begin
         @(negedge pclk);
         n++;
      end
      if (cfg_ack == ack_old) begin
         err_hs++;
         $display("cfg ack did not toggle after the flyback fall");
      end
   endtask

   task automatic dma_load();
      for (int i = 0; i < 16; i++) begin
         lb_model[i] = rand_bits(32);
         dma_data    = lb_model[i];
         dma_wr      = 1'b1;
         @(negedge pclk);
      end
      dma_wr = 1'b0;
   endtask

   task automatic run_frames(input int mode);
      chk_mode = mode;
      chk_on   = 1'b1;
      repeat (3) @(posedge vsync);
      @(negedge pclk);
   endtask

   initial begin
      h_sync    = 4;
      h_bp      = 6;
      h_res     = 32;
      h_fp      = 6;
      v_sync    = 2;
      v_bp      = 3;
      v_res     = 4;
      v_fp      = 2;
      bpp       = 2;
      wpl_m1    = 7;
      dma_wr    = 0;
      dma_data  = '0;
      flyback   = 0;
      cfg_req   = 0;
      test_card = 0;
      for (int i = 0; i < `VID_PAL_N; i++) begin
         pal_model[i] = 12'(rand_bits(12));
         palette[i*`VID_COL_W +: `VID_COL_W] = pal_model[i];
      end
      @(negedge rst_n);
      @(posedge rst_n);
      repeat (10) @(negedge pclk);
      resync(2'd2, 1'b1);
      run_frames(1);
      for (int m = 2; m >= 0; m--) begin                       // 4, 1 then 2 bpp
         resync(m == 2 ? 2'd2 : (m == 1 ? 2'd0 : 2'd1), 1'b0);
         dma_load();
         run_frames(2);
      end
      chk_on = 1'b0;
      if (pix_checked == 0) begin
         err_pixel++;
         $display("No displayed pixel was checked");
      end
      $display("errors: timing %0d pixel %0d handshake %0d", err_timing, err_pixel, err_hs);
      if (err_timing + err_pixel + err_hs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Watchdog
   initial begin
      #(limit_ns * 1ns);
      $display("Run exceeded its time limit");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== video_timing.f ====
+incdir+include
src/vid_pkg.sv
src/frame_resync.sv
src/timing_gen.sv
src/line_buffer.sv
src/pixel_path.sv
src/video_timing.sv
tb/tb_clk_gen.sv
tb/tb_video_timing.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_video_timing
FLIST     := video_timing.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard src/*.sv tb/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "\*\*\* FAILED \*\*\*" $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
